// ==== Makefile ====
# Verilator flow for the block game core

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_game_top
RTL_TOP   ?= game_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
RTL_FILES ?= logic/game_pkg.sv logic/key_conditioner.sv logic/settle_timer.sv \
             logic/game_fsm.sv logic/block_store.sv logic/score_keeper.sv \
             logic/seg7_decoder.sv logic/game_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
logic/game_pkg.sv
logic/key_conditioner.sv
logic/settle_timer.sv
logic/game_fsm.sv
logic/block_store.sv
logic/score_keeper.sv
logic/seg7_decoder.sv
logic/game_top.sv
test/game_checker.sv
test/tb_game_top.sv

// ==== logic/block_store.sv ====
// Block record store
`timescale 1ns/1ps
`default_nettype none

module block_store
	import game_pkg::*;
#(
	parameter int MAX_BLOCKS = 4
) (
	input  logic                                  clk,
	input  logic                                  reset_n,
	input  logic [SW_WIDTH-1:0]                   sw,
	input  logic                                  store_clear,
	input  logic                                  store_orient,
	input  logic                                  store_pos,
	input  logic [$clog2(MAX_BLOCKS+1)-1:0]       block_rd_slot,
	output logic [REC_WIDTH-1:0]                  block_rd_data,
	output logic                                  ball_dir,
	output logic                                  all_placed,
	output logic [DIGIT_WIDTH-1:0]                placed_count,
	output logic [DIGIT_WIDTH-1:0]                target_count
);

	localparam int SLOT_WIDTH = $clog2(MAX_BLOCKS + 1);

	// One record per block: x, y, orientation
	logic [REC_WIDTH-1:0] records [MAX_BLOCKS];

	logic [DIGIT_WIDTH-1:0] req_count;
	logic [DIGIT_WIDTH-1:0] clamped_count;

	// Requested count clamped to 1..MAX_BLOCKS
	assign req_count = DIGIT_WIDTH'(sw[SW_COUNT_LSB +: SW_COUNT_WIDTH]);
	always_comb begin
		if (req_count == '0)
			clamped_count = DIGIT_WIDTH'(1);
		else if (req_count > DIGIT_WIDTH'(MAX_BLOCKS))
			clamped_count = DIGIT_WIDTH'(MAX_BLOCKS);
		else
			clamped_count = req_count;
	end

	assign all_placed = (placed_count == target_count);

	always_ff @(posedge clk) begin
		if (!reset_n || store_clear) begin
			for (int i = 0; i < MAX_BLOCKS; i++)
				records[i] <= '0;
			placed_count <= '0;
			target_count <= !reset_n ? '0 : clamped_count;
		end else begin
			// Current slot is the one at placed_count
			for (int i = 0; i < MAX_BLOCKS; i++) begin
				if (DIGIT_WIDTH'(i) == placed_count) begin
					if (store_orient && !all_placed)
						records[i][REC_ORIENT_BIT] <= sw[SW_FLAG_BIT];
					if (store_pos) begin
						records[i][REC_X_LSB +: X_WIDTH] <= sw[SW_X_LSB +: X_WIDTH];
						records[i][REC_Y_LSB +: Y_WIDTH] <= sw[SW_Y_LSB +: Y_WIDTH];
					end
				end
			end
			if (store_pos)
				placed_count <= placed_count + 1'b1;
		end
	end

	// Aim press, same strobe once every block is down
	always_ff @(posedge clk) begin
		if (!reset_n)
			ball_dir <= 1'b0;
		else if (store_orient && all_placed)
			ball_dir <= sw[SW_FLAG_BIT];
	end

	// Read port, zero past the last slot
	always_comb begin
		block_rd_data = '0;
		for (int i = 0; i < MAX_BLOCKS; i++) begin
			if (SLOT_WIDTH'(i) == block_rd_slot)
				block_rd_data = records[i];
		end
	end

endmodule

`default_nettype wire

// ==== logic/game_fsm.sv ====
// Game phase controller
`timescale 1ns/1ps
`default_nettype none

module game_fsm
	import game_pkg::*;
#(
	parameter int ERASE_CYCLES = 1024
) (
	input  logic                   clk,
	input  logic                   reset_n,
	// Conditioned key presses
	input  logic [KEY_COUNT-1:0]   press,
	input  logic                   all_placed,
	input  logic                   scored,
	// Block store strobes
	output logic                   store_clear,
	output logic                   store_orient,
	output logic                   store_pos,
	output logic                   score_en,
	output logic                   play_active,
	output logic [STATE_WIDTH-1:0] state_led
);

	logic [STATE_WIDTH-1:0] state;
	logic [STATE_WIDTH-1:0] next_state;

	logic settle_en;
	logic settle_done;

	// ##########################################################
	// Settle intervals
	// ##########################################################

	// Runs only in the three settle phases
	assign settle_en = (state == ST_SETTLE_BEGIN) ||
	                   (state == ST_SETTLE_PLACE) ||
	                   (state == ST_SETTLE_RESULT);

	settle_timer #(
		.ERASE_CYCLES(ERASE_CYCLES)
	) u_settle_timer (
		.clk(clk),
		.reset_n(reset_n),
		.enable(settle_en),
		.done(settle_done)
	);

	// ##########################################################
	// Next state and strobes
	// ##########################################################

	always_comb begin
		next_state = state;
		store_clear = 1'b0;
		store_orient = 1'b0;
		store_pos = 1'b0;

		case (state)
			ST_IDLE: begin
				// New round, wipe the store and take the target count
				if (press[KEY_START]) begin
					store_clear = 1'b1;
					next_state = ST_SETTLE_BEGIN;
				end
			end
			ST_SETTLE_BEGIN: begin
				if (settle_done)
					next_state = ST_CHOOSE;
			end
			ST_CHOOSE: begin
				// Orientation of the next block
				if (press[KEY_BLOCK]) begin
					store_orient = 1'b1;
					next_state = ST_PLACE;
				end
			end
			ST_PLACE: begin
				// Position of the block, advances the slot
				if (press[KEY_SET]) begin
					store_pos = 1'b1;
					next_state = ST_SETTLE_PLACE;
				end
			end
			ST_SETTLE_PLACE: begin
				if (settle_done)
					next_state = all_placed ? ST_AIM : ST_CHOOSE;
			end
			ST_AIM: begin
				// Store sees all_placed and latches ball direction instead
				if (press[KEY_START]) begin
					store_orient = 1'b1;
					next_state = ST_PLAY;
				end
			end
			ST_PLAY: begin
				if (scored)
					next_state = ST_SETTLE_RESULT;
			end
			ST_SETTLE_RESULT: begin
				if (settle_done)
					next_state = ST_SHOW;
			end
			ST_SHOW: begin
				if (press[KEY_START])
					next_state = ST_IDLE;
			end
			default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	// Ball is in flight only during play
	assign score_en = (state == ST_PLAY);
	assign play_active = (state == ST_PLAY);
	assign state_led = state;

endmodule

`default_nettype wire

// ==== logic/game_pkg.sv ====
// Game control definitions
`default_nettype none

package game_pkg;

	// ##########################################################
	// Board inputs
	// ##########################################################
	localparam int SW_WIDTH = 18;
	localparam int KEY_COUNT = 3;

	// Key vector indices
	localparam int KEY_START = 0;
	localparam int KEY_BLOCK = 1;
	localparam int KEY_SET = 2;

	// Screen coordinates, 160 x 120
	localparam int X_WIDTH = 8;
	localparam int Y_WIDTH = 7;

	// ##########################################################
	// Block record layout
	// ##########################################################
	localparam int REC_WIDTH = 16;
	// Orientation, 1 for vertical
	localparam int REC_ORIENT_BIT = 0;
	localparam int REC_Y_LSB = 1;
	localparam int REC_X_LSB = 8;

	// Switch fields
	localparam int SW_X_LSB = 0;
	localparam int SW_Y_LSB = 8;
	// Orientation and ball direction share this switch
	localparam int SW_FLAG_BIT = 17;
	localparam int SW_COUNT_LSB = 0;
	localparam int SW_COUNT_WIDTH = 3;

	// Scores, counts and hex digits
	localparam int DIGIT_WIDTH = 4;

	// ##########################################################
	// Game phases
	// ##########################################################
	localparam int STATE_WIDTH = 4;
	localparam logic [STATE_WIDTH-1:0] ST_IDLE          = 4'd0;
	localparam logic [STATE_WIDTH-1:0] ST_SETTLE_BEGIN  = 4'd1;
	localparam logic [STATE_WIDTH-1:0] ST_CHOOSE        = 4'd2;
	localparam logic [STATE_WIDTH-1:0] ST_PLACE         = 4'd3;
	localparam logic [STATE_WIDTH-1:0] ST_SETTLE_PLACE  = 4'd4;
	localparam logic [STATE_WIDTH-1:0] ST_AIM           = 4'd5;
	localparam logic [STATE_WIDTH-1:0] ST_PLAY          = 4'd6;
	localparam logic [STATE_WIDTH-1:0] ST_SETTLE_RESULT = 4'd7;
	localparam logic [STATE_WIDTH-1:0] ST_SHOW          = 4'd8;

endpackage

`default_nettype wire

// ==== logic/game_top.sv ====
// Block game control top
`timescale 1ns/1ps
`default_nettype none

module game_top
	import game_pkg::*;
#(
	parameter int MAX_BLOCKS = 4,
	parameter int ERASE_CYCLES = 1024
) (
	input  logic                            clk,
	input  logic                            reset_n,
	// Active low keys
	input  logic [KEY_COUNT-1:0]            key,
	input  logic [SW_WIDTH-1:0]             sw,
	// Reports from the external ball engine
	input  logic                            hit,
	input  logic                            oob,
	input  logic [$clog2(MAX_BLOCKS+1)-1:0] block_rd_slot,
	output logic [REC_WIDTH-1:0]            block_rd_data,
	output logic                            ball_dir,
	output logic                            play_active,
	output logic [STATE_WIDTH-1:0]          state_led,
	output logic [6:0]                      hex0,
	output logic [6:0]                      hex2,
	output logic [6:0]                      hex4,
	output logic [6:0]                      hex5
);

	logic [KEY_COUNT-1:0]   press;
	logic                   store_clear;
	logic                   store_orient;
	logic                   store_pos;
	logic                   all_placed;
	logic                   score_en;
	logic                   scored;
	logic [DIGIT_WIDTH-1:0] placed_count;
	logic [DIGIT_WIDTH-1:0] target_count;
	logic [DIGIT_WIDTH-1:0] wins;
	logic [DIGIT_WIDTH-1:0] losses;

	// ##########################################################
	// Control
	// ##########################################################

	key_conditioner u_key_conditioner (
		.clk(clk),
		.reset_n(reset_n),
		.key(key),
		.press(press)
	);

	game_fsm #(
		.ERASE_CYCLES(ERASE_CYCLES)
	) u_game_fsm (
		.clk(clk),
		.reset_n(reset_n),
		.press(press),
		.all_placed(all_placed),
		.scored(scored),
		.store_clear(store_clear),
		.store_orient(store_orient),
		.store_pos(store_pos),
		.score_en(score_en),
		.play_active(play_active),
		.state_led(state_led)
	);

	// Records, counts and ball direction
	block_store #(
		.MAX_BLOCKS(MAX_BLOCKS)
	) u_block_store (
		.clk(clk),
		.reset_n(reset_n),
		.sw(sw),
		.store_clear(store_clear),
		.store_orient(store_orient),
		.store_pos(store_pos),
		.block_rd_slot(block_rd_slot),
		.block_rd_data(block_rd_data),
		.ball_dir(ball_dir),
		.all_placed(all_placed),
		.placed_count(placed_count),
		.target_count(target_count)
	);

	score_keeper u_score_keeper (
		.clk(clk),
		.reset_n(reset_n),
		.score_en(score_en),
		.hit(hit),
		.oob(oob),
		.scored(scored),
		.wins(wins),
		.losses(losses)
	);

	// ##########################################################
	// Displays
	// ##########################################################

	// Wins
	seg7_decoder u_hex0 (.digit(wins), .segments(hex0));
	// Losses
	seg7_decoder u_hex2 (.digit(losses), .segments(hex2));
	// Blocks placed so far
	seg7_decoder u_hex4 (.digit(placed_count), .segments(hex4));
	// Target count
	seg7_decoder u_hex5 (.digit(target_count), .segments(hex5));

endmodule

`default_nettype wire

// ==== logic/key_conditioner.sv ====
// Key press conditioner
`timescale 1ns/1ps
`default_nettype none

module key_conditioner
	import game_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset_n,
	// Active low push keys
	input  logic [KEY_COUNT-1:0] key,
	// One pulse per key going down
	output logic [KEY_COUNT-1:0] press
);

	// Two stage synchronizer
	logic [KEY_COUNT-1:0] sync_a;
	logic [KEY_COUNT-1:0] sync_b;
	// Last synchronized level, for edge detection
	logic [KEY_COUNT-1:0] prev_level;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			// All stages start released so nothing fires after reset
			sync_a <= '1;
			sync_b <= '1;
			prev_level <= '1;
			press <= '0;
		end else begin
			sync_a <= key;
			sync_b <= sync_a;
			prev_level <= sync_b;
			// Falling level means the key was just pressed
			press <= prev_level & ~sync_b;
		end
	end

endmodule

`default_nettype wire

// ==== logic/score_keeper.sv ====
// Win and loss counters
`timescale 1ns/1ps
`default_nettype none

module score_keeper
	import game_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset_n,
	// High while the ball is in play
	input  logic                   score_en,
	input  logic                   hit,
	input  logic                   oob,
	output logic                   scored,
	output logic [DIGIT_WIDTH-1:0] wins,
	output logic [DIGIT_WIDTH-1:0] losses
);

	// Any report during play ends the round
	assign scored = score_en && (hit || oob);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wins <= '0;
			losses <= '0;
		end else if (scored) begin
			// Hit wins over a simultaneous oob
			if (hit)
				wins <= wins + 1'b1;
			else
				losses <= losses + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/seg7_decoder.sv ====
// Seven segment hex decoder
`timescale 1ns/1ps
`default_nettype none

module seg7_decoder
	import game_pkg::*;
(
	input  logic [DIGIT_WIDTH-1:0] digit,
	// Active low, bit 0 is segment a, bit 6 is g
	output logic [6:0]             segments
);

	always_comb begin
		case (digit)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0011000;
			4'hA: segments = 7'b0001000;
			4'hB: segments = 7'b0000011;
			4'hC: segments = 7'b1000110;
			4'hD: segments = 7'b0100001;
			4'hE: segments = 7'b0000110;
			4'hF: segments = 7'b0001110;
			default: segments = 7'b1111111;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/settle_timer.sv ====
// Settle interval timer
`timescale 1ns/1ps
`default_nettype none

module settle_timer #(
	parameter int ERASE_CYCLES = 1024
) (
	input  logic clk,
	input  logic reset_n,
	input  logic enable,
	output logic done
);

	// Wide enough to hold ERASE_CYCLES-1
	localparam int CNT_WIDTH = (ERASE_CYCLES > 1) ? $clog2(ERASE_CYCLES) : 1;
	localparam logic [CNT_WIDTH-1:0] LAST = CNT_WIDTH'(ERASE_CYCLES - 1);

	logic [CNT_WIDTH-1:0] count;

	// Last cycle of the interval
	assign done = enable && (count == LAST);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			count <= '0;
		end else if (!enable || done) begin
			// Restart for the next interval
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== test/game_checker.sv ====
// Game model and checker
`timescale 1ns/1ps
`default_nettype none

module game_checker
	import game_pkg::*;
#(
	parameter int MAX_BLOCKS = 4,
	parameter int ERASE_CYCLES = 16
) (
	input  logic                            clk,
	input  logic                            reset_n,
	input  logic [KEY_COUNT-1:0]            key,
	input  logic [SW_WIDTH-1:0]             sw,
	input  logic                            hit,
	input  logic                            oob,
	input  logic [$clog2(MAX_BLOCKS+1)-1:0] block_rd_slot,
	input  logic [REC_WIDTH-1:0]            block_rd_data,
	input  logic                            ball_dir,
	input  logic                            play_active,
	input  logic [STATE_WIDTH-1:0]          state_led,
	input  logic [6:0]                      hex0,
	input  logic [6:0]                      hex2,
	input  logic [6:0]                      hex4,
	input  logic [6:0]                      hex5,
	output int                              error_count,
	output int                              check_count
);

	localparam int SLOT_WIDTH = $clog2(MAX_BLOCKS + 1);

	// Active low hex patterns, segment a in bit 0
	localparam logic [6:0] SEG_TABLE [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
	};

	// Key path, three edges from a low sample to the press
	logic [KEY_COUNT-1:0]   key_d1;
	logic [KEY_COUNT-1:0]   key_d2;
	logic [KEY_COUNT-1:0]   key_d3;
	logic [KEY_COUNT-1:0]   m_press;
	logic [STATE_WIDTH-1:0] m_state;
	logic [DIGIT_WIDTH-1:0] m_wins;
	logic [DIGIT_WIDTH-1:0] m_losses;
	logic [DIGIT_WIDTH-1:0] m_placed;
	logic [DIGIT_WIDTH-1:0] m_target;
	logic                   m_ball_dir;
	logic [REC_WIDTH-1:0]   m_rec [MAX_BLOCKS];
	logic                   settle_end;
	logic                   model_valid = 1'b0;
	int                     settle_cnt;
	int                     req;
	int                     errors = 0;
	int                     checks = 0;

	assign error_count = errors;
	assign check_count = checks;

	// ##########################################################
	// Game model, one step per clock edge
	// ##########################################################
	always @(posedge clk) begin
		if (!reset_n) begin
			key_d1 = '1;
			key_d2 = '1;
			key_d3 = '1;
			m_press = '0;
			m_state = ST_IDLE;
			m_wins = '0;
			m_losses = '0;
			m_placed = '0;
			m_target = '0;
			m_ball_dir = 1'b0;
			settle_cnt = 0;
			for (int i = 0; i < MAX_BLOCKS; i++)
				m_rec[i] = '0;
			model_valid = 1'b1;
		end else begin
			// Settle phases last ERASE_CYCLES cycles each
			settle_end = 1'b0;
			if (m_state inside {ST_SETTLE_BEGIN, ST_SETTLE_PLACE, ST_SETTLE_RESULT}) begin
				settle_cnt = settle_cnt + 1;
				if (settle_cnt == ERASE_CYCLES) begin
					settle_end = 1'b1;
					settle_cnt = 0;
				end
			end
			case (m_state)
				ST_IDLE: begin
					if (m_press[KEY_START]) begin
						for (int i = 0; i < MAX_BLOCKS; i++)
							m_rec[i] = '0;
						m_placed = '0;
						// Target clamped to 1..MAX_BLOCKS
						req = int'(sw[SW_COUNT_LSB +: SW_COUNT_WIDTH]);
						m_target = (req == 0) ? DIGIT_WIDTH'(1) :
							(req > MAX_BLOCKS) ? DIGIT_WIDTH'(MAX_BLOCKS) : DIGIT_WIDTH'(req);
						m_state = ST_SETTLE_BEGIN;
					end
				end
				ST_SETTLE_BEGIN: begin
					if (settle_end)
						m_state = ST_CHOOSE;
				end
				ST_CHOOSE: begin
					if (m_press[KEY_BLOCK]) begin
						for (int i = 0; i < MAX_BLOCKS; i++)
							if (DIGIT_WIDTH'(i) == m_placed)
								m_rec[i][REC_ORIENT_BIT] = sw[SW_FLAG_BIT];
						m_state = ST_PLACE;
					end
				end
				ST_PLACE: begin
					if (m_press[KEY_SET]) begin
						for (int i = 0; i < MAX_BLOCKS; i++) begin
							if (DIGIT_WIDTH'(i) == m_placed) begin
								m_rec[i][REC_X_LSB +: X_WIDTH] = sw[SW_X_LSB +: X_WIDTH];
								m_rec[i][REC_Y_LSB +: Y_WIDTH] = sw[SW_Y_LSB +: Y_WIDTH];
							end
						end
						m_placed = m_placed + 1'b1;
						m_state = ST_SETTLE_PLACE;
					end
				end
				ST_SETTLE_PLACE: begin
					if (settle_end)
						m_state = (m_placed == m_target) ? ST_AIM : ST_CHOOSE;
				end
				ST_AIM: begin
					if (m_press[KEY_START]) begin
						m_ball_dir = sw[SW_FLAG_BIT];
						m_state = ST_PLAY;
					end
				end
				ST_PLAY: begin
					// Hit counts when both reports arrive together
					if (hit || oob) begin
						if (hit)
							m_wins = m_wins + 1'b1;
						else
							m_losses = m_losses + 1'b1;
						m_state = ST_SETTLE_RESULT;
					end
				end
				ST_SETTLE_RESULT: begin
					if (settle_end)
						m_state = ST_SHOW;
				end
				ST_SHOW: begin
					if (m_press[KEY_START])
						m_state = ST_IDLE;
				end
				default: m_state = ST_IDLE;
			endcase
			// Falling synchronized level gives the press
			m_press = key_d3 & ~key_d2;
			key_d3 = key_d2;
			key_d2 = key_d1;
			key_d1 = key;
		end
	end

	// Slots past the last record read zero
	function automatic logic [REC_WIDTH-1:0] expected_read(input logic [SLOT_WIDTH-1:0] slot);
		logic [REC_WIDTH-1:0] data;
		data = '0;
		for (int i = 0; i < MAX_BLOCKS; i++)
			if (SLOT_WIDTH'(i) == slot)
				data = m_rec[i];
		return data;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// ##########################################################
	// Compare on the falling edge, outputs are settled
	// ##########################################################
	always @(negedge clk) begin
		if (model_valid) begin
			check_value("state_led", 32'(state_led), 32'(m_state));
			check_value("play_active", 32'(play_active), 32'(m_state == ST_PLAY));
			check_value("ball_dir", 32'(ball_dir), 32'(m_ball_dir));
			check_value("hex0", 32'(hex0), 32'(SEG_TABLE[m_wins]));
			check_value("hex2", 32'(hex2), 32'(SEG_TABLE[m_losses]));
			check_value("hex4", 32'(hex4), 32'(SEG_TABLE[m_placed]));
			check_value("hex5", 32'(hex5), 32'(SEG_TABLE[m_target]));
			check_value("block_rd_data", 32'(block_rd_data), 32'(expected_read(block_rd_slot)));
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_game_top.sv ====
// Block game testbench
`timescale 1ns/1ps
`default_nettype none

module tb_game_top
	import game_pkg::*;
();

	localparam int MAX_BLOCKS = 4;
	localparam int ERASE_CYCLES = 16;
	localparam int SLOT_WIDTH = $clog2(MAX_BLOCKS + 1);
	localparam int ROUNDS = 24;
	// Longest state wait in cycles
	localparam int WAIT_LIMIT = 100;

	logic                   clk;
	logic                   reset_n;
	logic [KEY_COUNT-1:0]   key;
	logic [SW_WIDTH-1:0]    sw;
	logic                   hit;
	logic                   oob;
	logic [SLOT_WIDTH-1:0]  block_rd_slot;
	logic [REC_WIDTH-1:0]   block_rd_data;
	logic                   ball_dir;
	logic                   play_active;
	logic [STATE_WIDTH-1:0] state_led;
	logic [6:0]             hex0;
	logic [6:0]             hex2;
	logic [6:0]             hex4;
	logic [6:0]             hex5;
	int                     error_count;
	int                     check_count;
	integer                 seed;
	logic                   timed_out;

	game_top #(
		.MAX_BLOCKS(MAX_BLOCKS),
		.ERASE_CYCLES(ERASE_CYCLES)
	) u_game_top (
		.clk(clk), .reset_n(reset_n), .key(key), .sw(sw), .hit(hit), .oob(oob),
		.block_rd_slot(block_rd_slot), .block_rd_data(block_rd_data),
		.ball_dir(ball_dir), .play_active(play_active), .state_led(state_led),
		.hex0(hex0), .hex2(hex2), .hex4(hex4), .hex5(hex5)
	);

	game_checker #(
		.MAX_BLOCKS(MAX_BLOCKS),
		.ERASE_CYCLES(ERASE_CYCLES)
	) u_game_checker (
		.clk(clk), .reset_n(reset_n), .key(key), .sw(sw), .hit(hit), .oob(oob),
		.block_rd_slot(block_rd_slot), .block_rd_data(block_rd_data),
		.ball_dir(ball_dir), .play_active(play_active), .state_led(state_led),
		.hex0(hex0), .hex2(hex2), .hex4(hex4), .hex5(hex5),
		.error_count(error_count), .check_count(check_count)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'(($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
	endfunction

	// Returns once the state is one of two, gives up after WAIT_LIMIT
	task automatic wait_state(input logic [STATE_WIDTH-1:0] first,
		input logic [STATE_WIDTH-1:0] second, input string what);
		int cycles;
		cycles = 0;
		while (!timed_out) begin
			@(negedge clk);
			if (state_led === first || state_led === second)
				break;
			cycles++;
			if (cycles >= WAIT_LIMIT) begin
				timed_out = 1'b1;
				$display("Timeout at %0t waiting for %s, state is %0d", $time, what, state_led);
			end
		end
	endtask

	// Holds one key low for 3 to 20 cycles, switches keep moving
	task automatic press_key(input int idx);
		int hold;
		hold = rand_range(3, 20);
		@(posedge clk);
		key <= ~KEY_COUNT'(1 << idx);
		repeat (hold) begin
			@(posedge clk);
			sw <= SW_WIDTH'($random(seed));
			block_rd_slot <= SLOT_WIDTH'($random(seed));
		end
		key <= '1;
		// Let the release pass the synchronizer
		repeat (4) @(posedge clk);
	endtask

	// One cycle report, hit, oob or both
	task automatic send_report();
		int pick;
		pick = rand_range(1, 3);
		@(posedge clk);
		hit <= pick[0];
		oob <= pick[1];
		@(posedge clk);
		hit <= 1'b0;
		oob <= 1'b0;
	endtask

	// Reads every slot value, unused ones included
	task automatic sweep_slots();
		for (int s = 0; s < (1 << SLOT_WIDTH); s++) begin
			@(posedge clk);
			block_rd_slot <= SLOT_WIDTH'(s);
		end
	endtask

	// ##########################################################
	// Rounds of the game
	// ##########################################################
	initial begin
		seed = 32'h814f1b82;
		timed_out = 1'b0;
		reset_n = 1'b0;
		key = '1;
		sw = '0;
		hit = 1'b0;
		oob = 1'b0;
		block_rd_slot = '0;
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
		repeat (3) @(posedge clk);
		for (int round = 0; round < ROUNDS && !timed_out; round++) begin
			// Set key means nothing in idle
			if (rand_range(0, 3) == 0)
				press_key(KEY_SET);
			press_key(KEY_START);
			wait_state(ST_CHOOSE, ST_CHOOSE, "the choose phase");
			// Last round's records must be gone
			sweep_slots();
			for (int b = 0; b < MAX_BLOCKS && !timed_out && state_led !== ST_AIM; b++) begin
				if (rand_range(0, 3) == 0)
					press_key(KEY_SET);
				press_key(KEY_BLOCK);
				wait_state(ST_PLACE, ST_PLACE, "the place phase");
				press_key(KEY_SET);
				wait_state(ST_CHOOSE, ST_AIM, "the end of the place settle");
			end
			wait_state(ST_AIM, ST_AIM, "the aim phase");
			sweep_slots();
			// Reports outside play are dropped
			send_report();
			press_key(KEY_START);
			wait_state(ST_PLAY, ST_PLAY, "the play phase");
			if (rand_range(0, 3) == 0)
				press_key(KEY_BLOCK);
			repeat (rand_range(0, 8)) @(posedge clk);
			send_report();
			wait_state(ST_SHOW, ST_SHOW, "the result display");
			press_key(KEY_START);
			wait_state(ST_IDLE, ST_IDLE, "the idle phase");
		end
		repeat (4) @(posedge clk);
		$display("Checks: %0d, mismatches: %0d, timeouts: %0d",
			check_count, error_count, timed_out);
		if (timed_out || error_count != 0)
			$display("Test failed");
		else
			$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire
